// ==== tb.f ====
source/cmac_pkg.sv
source/port_regs_pkg.sv
source/stats_if.sv
source/stream_stats.sv
source/port_regs.sv
source/alveo_cmac_port.sv
testbench/tb_alveo_cmac_port.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the port testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_alveo_cmac_port

verilator --binary --timing --timescale 1ns/100ps \
    -f tb.f --top-module "$TOP" -o sim_"$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    echo "Failure reported, see $LOG"
    exit 1
fi

echo "No failure reported in $LOG"
exit 0

// ==== testbench/tb_alveo_cmac_port.sv ====
module tb_alveo_cmac_port
    import cmac_pkg::*;
    import port_regs_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // ======================================================================
    // Constants and table types
    // ======================================================================
    localparam int TB_PORT_ID      = 5;
    localparam int DBW             = AXIS_DATA_BYTE_WID;
    localparam int CLK_HALF        = 50;
    localparam int DRIVE_DELAY     = 10;
    localparam int NUM_FRAMES      = 8;
    // Rows from here on are sent after the counters are cleared
    localparam int CLEAR_ROW       = 6;
    localparam int MAX_BEATS       = 6;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * MAX_BEATS * 4 + 200;

    typedef logic [DBW*8-1:0] data_t;
    typedef logic [DBW-1:0]   keep_t;

    // One frame with direction, length, last-beat keep and error flag
    typedef struct packed {
        logic       rx;
        logic [3:0] beats;
        keep_t      last_keep;
        logic       err;
    } frame_row_t;

    // One register access with its expected outcome
    typedef struct packed {
        logic                     wr;
        logic [AXIL_ADDR_WID-1:0] addr;
        axil_data_t               wdata;
        axil_data_t               exp_data;
        axil_resp_e               exp_resp;
    } reg_row_t;

    // Ready stalls are drawn per beat while sending
    frame_row_t frame_tab [NUM_FRAMES] = '{
        '{1'b0, 4'd1, 8'h0F, 1'b0},
        '{1'b1, 4'd3, 8'hFF, 1'b0},
        '{1'b0, 4'd4, 8'h7F, 1'b1},
        '{1'b1, 4'd2, 8'h01, 1'b1},
        '{1'b0, 4'd6, 8'h3F, 1'b0},
        '{1'b1, 4'd5, 8'h1F, 1'b0},
        '{1'b0, 4'd2, 8'h03, 1'b1},
        '{1'b1, 4'd3, 8'hFF, 1'b1}
    };

    // ======================================================================
    // DUT signals
    // ======================================================================
    logic        clk = 1'b0;
    logic        rst_n;
    logic        tx_tvalid, tx_tready, tx_tlast;
    data_t       tx_tdata;
    keep_t       tx_tkeep;
    axis_tuser_t tx_tuser;
    logic        mac_tx_tvalid, mac_tx_tready, mac_tx_tlast;
    data_t       mac_tx_tdata;
    keep_t       mac_tx_tkeep;
    axis_tuser_t mac_tx_tuser;
    logic        mac_rx_tvalid, mac_rx_tready, mac_rx_tlast;
    data_t       mac_rx_tdata;
    keep_t       mac_rx_tkeep;
    axis_tuser_t mac_rx_tuser;
    logic        rx_tvalid, rx_tready, rx_tlast;
    data_t       rx_tdata;
    keep_t       rx_tkeep;
    axis_tuser_t rx_tuser;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [AXIL_ADDR_WID-1:0] awaddr, araddr;
    axil_data_t  wdata, rdata;
    axil_resp_e  bresp, rresp;

    // Running totals indexed 0 for transmit and 1 for receive
    stat_cnt_t   tot_frames [2];
    stat_cnt_t   tot_bytes [2];
    stat_cnt_t   tot_bad [2];
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    reg_row_t    reg_q [$];

    alveo_cmac_port #(
        .PORT_ID ( TB_PORT_ID )
    ) uut (
        .*
    );

    always #CLK_HALF clk = ~clk;

    // ======================================================================
    // Compare tasks
    // ======================================================================
    task automatic check_beat(input string test, input int beat,
                              input data_t exp_d, input data_t act_d,
                              input keep_t exp_k, input keep_t act_k,
                              input logic exp_l, input logic act_l,
                              input axis_tuser_t exp_u, input axis_tuser_t act_u);
        if (act_d !== exp_d) begin
            $display("[ERROR] %s beat %0d tdata: expected 0x%h actual 0x%h",
                     test, beat, exp_d, act_d);
            errors++;
        end
        if (act_k !== exp_k) begin
            $display("[ERROR] %s beat %0d tkeep: expected 0x%h actual 0x%h",
                     test, beat, exp_k, act_k);
            errors++;
        end
        if (act_l !== exp_l || act_u !== exp_u) begin
            $display("[ERROR] %s beat %0d tlast/tuser: expected %b/%b actual %b/%b",
                     test, beat, exp_l, exp_u, act_l, act_u);
            errors++;
        end
    endtask

    task automatic check_reg(input string test, input reg_addr_e ra,
                             input axil_data_t exp, input axil_data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h",
                     test, reg_label(ra), exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string test, input axil_resp_e exp,
                              input axil_resp_e act);
        if (act !== exp) begin
            $display("[ERROR] %s: response expected %s actual %s (%b)",
                     test, exp.name(), act.name(), act);
            errors++;
        end
    endtask

    // One status line per finished test
    task automatic finish_test(input string test, input int errs_at_start);
        tests_run++;
        if (errors != errs_at_start) begin
            tests_failed++;
            $display("[FAIL] %s", test);
        end else begin
            $display("[PASS] %s", test);
        end
    endtask

    // ======================================================================
    // Line-side stream model
    // ======================================================================
    function automatic data_t beat_data(input int row, input int beat);
        return data_t'({32'(row), 32'(beat)}) ^ {DBW{8'h5A}};
    endfunction

    // Full keep except on the last beat
    function automatic keep_t beat_keep(input frame_row_t f, input int beat);
        return (beat == int'(f.beats) - 1) ? f.last_keep : '1;
    endfunction

    function automatic string reg_label(input logic [AXIL_ADDR_WID-1:0] addr);
        reg_addr_e ra;
        ra = reg_addr_e'(addr);
        if (ra.name() == "") begin
            return $sformatf("addr 0x%02h", addr);
        end
        return ra.name();
    endfunction

    // Source side of one path plus the sink ready of the same path
    task automatic drive_stream(input logic rx, input logic vld, input data_t d,
                                input keep_t k, input logic l, input axis_tuser_t u,
                                input logic rdy);
        if (rx) begin
            mac_rx_tvalid = vld;
            mac_rx_tdata  = d;
            mac_rx_tkeep  = k;
            mac_rx_tlast  = l;
            mac_rx_tuser  = u;
            rx_tready     = rdy;
        end else begin
            tx_tvalid     = vld;
            tx_tdata      = d;
            tx_tkeep      = k;
            tx_tlast      = l;
            tx_tuser      = u;
            mac_tx_tready = rdy;
        end
    endtask

    task automatic sample_stream(input logic rx, output logic src_rdy,
                                 output logic snk_vld, output data_t d,
                                 output keep_t k, output logic l, output axis_tuser_t u);
        if (rx) begin
            src_rdy = mac_rx_tready;
            snk_vld = rx_tvalid;
            d       = rx_tdata;
            k       = rx_tkeep;
            l       = rx_tlast;
            u       = rx_tuser;
        end else begin
            src_rdy = tx_tready;
            snk_vld = mac_tx_tvalid;
            d       = mac_tx_tdata;
            k       = mac_tx_tkeep;
            l       = mac_tx_tlast;
            u       = mac_tx_tuser;
        end
    endtask

    // Starts and ends on a rising edge
    task automatic send_frame(input int row, input string test);
        frame_row_t  f;
        int          nb;
        int          sent;
        int          seen;
        logic        snk_rdy;
        logic        src_rdy;
        logic        snk_vld;
        data_t       act_d;
        keep_t       act_k;
        logic        act_l;
        axis_tuser_t act_u;
        f    = frame_tab[row];
        nb   = int'(f.beats);
        sent = 0;
        seen = 0;
        while (sent < nb) begin
            #DRIVE_DELAY;
            // Sink stalls about one cycle in four
            snk_rdy = (($urandom % 4) != 0);
            drive_stream(f.rx, 1'b1, beat_data(row, sent), beat_keep(f, sent),
                         sent == nb - 1, (sent == nb - 1) && f.err, snk_rdy);
            @(posedge clk);
            sample_stream(f.rx, src_rdy, snk_vld, act_d, act_k, act_l, act_u);
            if (src_rdy !== snk_rdy) begin
                $display("%s: source ready does not follow sink ready on beat %0d",
                         test, sent);
                errors++;
            end
            // Sink view compared in send order
            if (snk_vld && snk_rdy) begin
                if (seen < nb) begin
                    check_beat(test, seen, beat_data(row, seen), act_d,
                               beat_keep(f, seen), act_k, seen == nb - 1, act_l,
                               (seen == nb - 1) && f.err, act_u);
                end
                seen++;
            end
            if (src_rdy) begin
                sent++;
            end
        end
        #DRIVE_DELAY;
        drive_stream(f.rx, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
        @(posedge clk);
        if (seen != nb) begin
            $display("%s: sink saw %0d beats but %0d were sent", test, seen, nb);
            errors++;
        end
    endtask

    task automatic run_frame(input int row);
        frame_row_t f;
        string      name;
        int         errs0;
        f     = frame_tab[row];
        errs0 = errors;
        name  = $sformatf("frame %0d %s", row, f.rx ? "rx" : "tx");
        send_frame(row, name);
        // Bytes are full beats plus the keep bits of the last beat
        tot_frames[f.rx] = tot_frames[f.rx] + 1;
        tot_bytes[f.rx]  = tot_bytes[f.rx]
                         + stat_cnt_t'((int'(f.beats) - 1) * DBW + $countones(f.last_keep));
        if (f.err) begin
            tot_bad[f.rx] = tot_bad[f.rx] + 1;
        end
        finish_test(name, errs0);
    endtask

    // ======================================================================
    // AXI4-Lite master model
    // ======================================================================
    task automatic axil_read(input logic [AXIL_ADDR_WID-1:0] addr,
                             output axil_data_t data, output axil_resp_e resp);
        #DRIVE_DELAY;
        arvalid = 1'b1;
        araddr  = addr;
        @(posedge clk);
        while (!arready) @(posedge clk);
        #DRIVE_DELAY;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b1;
        @(posedge clk);
        while (!rvalid) @(posedge clk);
        data = rdata;
        resp = rresp;
        #DRIVE_DELAY;
        rready = 1'b0;
        @(posedge clk);
    endtask

    // Address and data offered together
    task automatic axil_write(input logic [AXIL_ADDR_WID-1:0] addr,
                              input axil_data_t data, output axil_resp_e resp);
        #DRIVE_DELAY;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        @(posedge clk);
        while (!(awready && wready)) @(posedge clk);
        #DRIVE_DELAY;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(posedge clk);
        while (!bvalid) @(posedge clk);
        resp = bresp;
        #DRIVE_DELAY;
        bready = 1'b0;
        @(posedge clk);
    endtask

    // ======================================================================
    // Register table
    // ======================================================================
    function automatic void push_read(input logic [AXIL_ADDR_WID-1:0] addr,
                                      input axil_data_t exp, input axil_resp_e resp);
        reg_q.push_back('{1'b0, addr, '0, exp, resp});
    endfunction

    function automatic void push_write(input logic [AXIL_ADDR_WID-1:0] addr,
                                       input axil_data_t data, input axil_resp_e resp);
        reg_q.push_back('{1'b1, addr, data, '0, resp});
    endfunction

    // All six counters against the running totals
    function automatic void push_counter_reads();
        push_read(REG_TX_FRAMES, tot_frames[0], RESP_OKAY);
        push_read(REG_TX_BYTES, tot_bytes[0], RESP_OKAY);
        push_read(REG_TX_BAD, tot_bad[0], RESP_OKAY);
        push_read(REG_RX_FRAMES, tot_frames[1], RESP_OKAY);
        push_read(REG_RX_BYTES, tot_bytes[1], RESP_OKAY);
        push_read(REG_RX_BAD, tot_bad[1], RESP_OKAY);
    endfunction

    function automatic void clear_totals();
        for (int i = 0; i < 2; i++) begin
            tot_frames[i] = '0;
            tot_bytes[i]  = '0;
            tot_bad[i]    = '0;
        end
    endfunction

    task automatic run_reg_table();
        reg_row_t   r;
        string      name;
        int         errs0;
        axil_data_t data;
        axil_resp_e resp;
        foreach (reg_q[i]) begin
            r     = reg_q[i];
            errs0 = errors;
            if (r.wr) begin
                name = $sformatf("write %s", reg_label(r.addr));
                axil_write(r.addr, r.wdata, resp);
            end else begin
                name = $sformatf("read %s", reg_label(r.addr));
                axil_read(r.addr, data, resp);
                check_reg(name, reg_addr_e'(r.addr), r.exp_data, data);
            end
            check_resp(name, r.exp_resp, resp);
            finish_test(name, errs0);
        end
        reg_q.delete();
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        void'($urandom(32'h1793));
        rst_n    = 1'b0;
        drive_stream(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
        drive_stream(1'b1, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b0;
        clear_totals();
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(posedge clk);

        // Traffic on both paths before the clear
        for (int i = 0; i < CLEAR_ROW; i++) begin
            run_frame(i);
        end

        push_read(REG_PORT_ID, axil_data_t'(TB_PORT_ID), RESP_OKAY);
        push_counter_reads();
        // Counters must survive an unmapped write
        push_read(8'h40, '0, RESP_SLVERR);
        push_write(8'h40, 32'h1, RESP_SLVERR);
        push_counter_reads();
        push_read(REG_CONTROL, '0, RESP_OKAY);
        push_write(REG_CONTROL, 32'h1, RESP_OKAY);
        clear_totals();
        push_counter_reads();
        run_reg_table();

        // Counting restarts from zero
        for (int i = CLEAR_ROW; i < NUM_FRAMES; i++) begin
            run_frame(i);
        end
        push_counter_reads();
        run_reg_table();

        $display("summary: %0d tests run, %0d with errors, %0d mismatches",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d clock periods", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule : tb_alveo_cmac_port

// ==== source/alveo_cmac_port.sv ====
module alveo_cmac_port
    import cmac_pkg::*;
    import port_regs_pkg::*;
#(
    parameter int PORT_ID            = 0,
    parameter int AXIS_DATA_BYTE_WID = cmac_pkg::AXIS_DATA_BYTE_WID
) (
    input  logic                            clk,
    input  logic                            rst_n,

    // Host transmit stream in
    input  logic                            tx_tvalid,
    output logic                            tx_tready,
    input  logic [AXIS_DATA_BYTE_WID*8-1:0] tx_tdata,
    input  logic [AXIS_DATA_BYTE_WID-1:0]   tx_tkeep,
    input  logic                            tx_tlast,
    input  axis_tuser_t                     tx_tuser,
    // Toward the MAC
    output logic                            mac_tx_tvalid,
    input  logic                            mac_tx_tready,
    output logic [AXIS_DATA_BYTE_WID*8-1:0] mac_tx_tdata,
    output logic [AXIS_DATA_BYTE_WID-1:0]   mac_tx_tkeep,
    output logic                            mac_tx_tlast,
    output axis_tuser_t                     mac_tx_tuser,

    // Receive stream from the MAC
    input  logic                            mac_rx_tvalid,
    output logic                            mac_rx_tready,
    input  logic [AXIS_DATA_BYTE_WID*8-1:0] mac_rx_tdata,
    input  logic [AXIS_DATA_BYTE_WID-1:0]   mac_rx_tkeep,
    input  logic                            mac_rx_tlast,
    input  axis_tuser_t                     mac_rx_tuser,
    // Out to the host
    output logic                            rx_tvalid,
    input  logic                            rx_tready,
    output logic [AXIS_DATA_BYTE_WID*8-1:0] rx_tdata,
    output logic [AXIS_DATA_BYTE_WID-1:0]   rx_tkeep,
    output logic                            rx_tlast,
    output axis_tuser_t                     rx_tuser,

    // AXI4-Lite register access
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [AXIL_ADDR_WID-1:0]        awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  axil_data_t                      wdata,
    output logic                            bvalid,
    input  logic                            bready,
    output axil_resp_e                      bresp,
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [AXIL_ADDR_WID-1:0]        araddr,
    output logic                            rvalid,
    input  logic                            rready,
    output axil_data_t                      rdata,
    output axil_resp_e                      rresp
);

    // ======================================================================
    // Counter links
    // ======================================================================
    stats_if tx_stats ();
    stats_if rx_stats ();

    // ======================================================================
    // Transmit path, host to MAC
    // ======================================================================
    stream_stats #(
        .AXIS_DATA_BYTE_WID ( AXIS_DATA_BYTE_WID )
    ) u_tx_stats (
        .clk,
        .rst_n,
        .s_tvalid ( tx_tvalid ),
        .s_tready ( tx_tready ),
        .s_tdata  ( tx_tdata ),
        .s_tkeep  ( tx_tkeep ),
        .s_tlast  ( tx_tlast ),
        .s_tuser  ( tx_tuser ),
        .m_tvalid ( mac_tx_tvalid ),
        .m_tready ( mac_tx_tready ),
        .m_tdata  ( mac_tx_tdata ),
        .m_tkeep  ( mac_tx_tkeep ),
        .m_tlast  ( mac_tx_tlast ),
        .m_tuser  ( mac_tx_tuser ),
        .stats    ( tx_stats )
    );

    // ======================================================================
    // Receive path, MAC to host
    // ======================================================================
    stream_stats #(
        .AXIS_DATA_BYTE_WID ( AXIS_DATA_BYTE_WID )
    ) u_rx_stats (
        .clk,
        .rst_n,
        .s_tvalid ( mac_rx_tvalid ),
        .s_tready ( mac_rx_tready ),
        .s_tdata  ( mac_rx_tdata ),
        .s_tkeep  ( mac_rx_tkeep ),
        .s_tlast  ( mac_rx_tlast ),
        .s_tuser  ( mac_rx_tuser ),
        .m_tvalid ( rx_tvalid ),
        .m_tready ( rx_tready ),
        .m_tdata  ( rx_tdata ),
        .m_tkeep  ( rx_tkeep ),
        .m_tlast  ( rx_tlast ),
        .m_tuser  ( rx_tuser ),
        .stats    ( rx_stats )
    );

    // ======================================================================
    // Registers
    // ======================================================================
    port_regs #(
        .PORT_ID ( PORT_ID )
    ) u_port_regs (
        .clk,
        .rst_n,
        .awvalid,
        .awready,
        .awaddr,
        .wvalid,
        .wready,
        .wdata,
        .bvalid,
        .bready,
        .bresp,
        .arvalid,
        .arready,
        .araddr,
        .rvalid,
        .rready,
        .rdata,
        .rresp,
        .tx_stats ( tx_stats ),
        .rx_stats ( rx_stats )
    );

endmodule : alveo_cmac_port

// ==== source/port_regs.sv ====
module port_regs
    import port_regs_pkg::*;
#(
    parameter int PORT_ID = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // Write address channel
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [AXIL_ADDR_WID-1:0] awaddr,
    // Write data channel
    input  logic                     wvalid,
    output logic                     wready,
    input  axil_data_t               wdata,
    // Write response channel
    output logic                     bvalid,
    input  logic                     bready,
    output axil_resp_e               bresp,
    // Read address channel
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [AXIL_ADDR_WID-1:0] araddr,
    // Read data channel
    output logic                     rvalid,
    input  logic                     rready,
    output axil_data_t               rdata,
    output axil_resp_e               rresp,

    // Counter sets from both paths
    stats_if.regs                    tx_stats,
    stats_if.regs                    rx_stats
);

    // Same two-state shape for both channels
    typedef enum logic {
        ST_IDLE,
        ST_RESP
    } chan_state_e;

    chan_state_e wr_state;
    chan_state_e rd_state;
    logic        wr_fire;
    logic        rd_fire;
    logic        clear_q;
    axil_data_t  rd_value;

    // Offset is one of the eight registers
    function automatic logic addr_mapped(input logic [AXIL_ADDR_WID-1:0] addr);
        case (addr)
            REG_PORT_ID, REG_CONTROL,
            REG_TX_FRAMES, REG_TX_BYTES, REG_TX_BAD,
            REG_RX_FRAMES, REG_RX_BYTES, REG_RX_BAD: addr_mapped = 1'b1;
            default:                                 addr_mapped = 1'b0;
        endcase
    endfunction

    // ======================================================================
    // Write path
    // ======================================================================
    // Address and data taken together, only with no response outstanding
    assign wr_fire = awvalid && wvalid && (wr_state == ST_IDLE);
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign bvalid  = (wr_state == ST_RESP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= ST_IDLE;
            clear_q  <= 1'b0;
        end else begin
            // Single pulse the cycle after acceptance
            clear_q <= wr_fire && (awaddr == REG_CONTROL) && wdata[0];
            case (wr_state)
                ST_IDLE: if (wr_fire) wr_state <= ST_RESP;
                ST_RESP: if (bready)  wr_state <= ST_IDLE;
                default:              wr_state <= ST_IDLE;
            endcase
        end
    end

    // Response code latched with the accepted address
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= addr_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Both paths cleared together
    assign tx_stats.clear = clear_q;
    assign rx_stats.clear = clear_q;

    // ======================================================================
    // Read path
    // ======================================================================
    assign arready = (rd_state == ST_IDLE);
    assign rd_fire = arvalid && arready;
    assign rvalid  = (rd_state == ST_RESP);

    // Register select, control and unmapped read as zero
    always_comb begin
        case (araddr)
            REG_PORT_ID:   rd_value = axil_data_t'(PORT_ID);
            REG_TX_FRAMES: rd_value = tx_stats.frames;
            REG_TX_BYTES:  rd_value = tx_stats.bytes;
            REG_TX_BAD:    rd_value = tx_stats.bad_frames;
            REG_RX_FRAMES: rd_value = rx_stats.frames;
            REG_RX_BYTES:  rd_value = rx_stats.bytes;
            REG_RX_BAD:    rd_value = rx_stats.bad_frames;
            default:       rd_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_state <= ST_IDLE;
        end else begin
            case (rd_state)
                ST_IDLE: if (rd_fire) rd_state <= ST_RESP;
                ST_RESP: if (rready)  rd_state <= ST_IDLE;
                default:              rd_state <= ST_IDLE;
            endcase
        end
    end

    // Counter snapshot at acceptance, held until rready
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_value;
            rresp <= addr_mapped(araddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule : port_regs

// ==== source/stream_stats.sv ====
module stream_stats
    import cmac_pkg::*;
#(
    parameter int AXIS_DATA_BYTE_WID = cmac_pkg::AXIS_DATA_BYTE_WID
) (
    input  logic                            clk,
    input  logic                            rst_n,

    // Upstream stream
    input  logic                            s_tvalid,
    output logic                            s_tready,
    input  logic [AXIS_DATA_BYTE_WID*8-1:0] s_tdata,
    input  logic [AXIS_DATA_BYTE_WID-1:0]   s_tkeep,
    input  logic                            s_tlast,
    input  axis_tuser_t                     s_tuser,

    // Downstream stream
    output logic                            m_tvalid,
    input  logic                            m_tready,
    output logic [AXIS_DATA_BYTE_WID*8-1:0] m_tdata,
    output logic [AXIS_DATA_BYTE_WID-1:0]   m_tkeep,
    output logic                            m_tlast,
    output axis_tuser_t                     m_tuser,

    // Counters out, clear in
    stats_if.counter                        stats
);

    // Wide enough to hold a full keep count
    localparam int KEEP_CNT_WID = $clog2(AXIS_DATA_BYTE_WID + 1);

    logic                    xfer;
    logic [KEEP_CNT_WID-1:0] keep_cnt;

    // ======================================================================
    // Pass-through
    // ======================================================================
    // Zero latency, sink back-pressure goes straight to the source
    assign m_tvalid = s_tvalid;
    assign m_tdata  = s_tdata;
    assign m_tkeep  = s_tkeep;
    assign m_tlast  = s_tlast;
    assign m_tuser  = s_tuser;
    assign s_tready = m_tready;

    // Beat moves this cycle
    assign xfer = s_tvalid && m_tready;

    // Valid bytes in the current beat
    always_comb begin
        keep_cnt = '0;
        for (int i = 0; i < AXIS_DATA_BYTE_WID; i++) begin
            keep_cnt = keep_cnt + KEEP_CNT_WID'(s_tkeep[i]);
        end
    end

    // ======================================================================
    // Counters
    // ======================================================================
    // Clear beats a transfer in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n || stats.clear) begin
            stats.frames     <= '0;
            stats.bytes      <= '0;
            stats.bad_frames <= '0;
        end else if (xfer) begin
            stats.bytes <= stats.bytes + stat_cnt_t'(keep_cnt);
            // Frame end, error flag only counts here
            if (s_tlast) begin
                stats.frames <= stats.frames + stat_cnt_t'(1);
                if (s_tuser) begin
                    stats.bad_frames <= stats.bad_frames + stat_cnt_t'(1);
                end
            end
        end
    end

endmodule : stream_stats

// ==== source/stats_if.sv ====
interface stats_if
    import cmac_pkg::*;
();

    // Counts for one stream path
    stat_cnt_t frames;
    stat_cnt_t bytes;
    stat_cnt_t bad_frames;

    // One-cycle clear request from the register block
    logic      clear;

    // Statistics block side
    modport counter (
        output frames,
        output bytes,
        output bad_frames,
        input  clear
    );

    // Register block side
    modport regs (
        input  frames,
        input  bytes,
        input  bad_frames,
        output clear
    );

endinterface : stats_if

// ==== source/port_regs_pkg.sv ====
package port_regs_pkg;

    // ======================================================================
    // AXI4-Lite geometry
    // ======================================================================

    // Byte address into the port register space
    localparam int AXIL_ADDR_WID = 8;
    localparam int AXIL_DATA_WID = 32;

    typedef logic [AXIL_DATA_WID-1:0] axil_data_t;

    // ======================================================================
    // Register map
    // ======================================================================

    // Byte offsets, one 32-bit word each
    typedef enum logic [AXIL_ADDR_WID-1:0] {
        REG_PORT_ID   = 8'h00,
        // Bit 0 written as 1 clears every counter, reads back 0
        REG_CONTROL   = 8'h04,
        REG_TX_FRAMES = 8'h08,
        REG_TX_BYTES  = 8'h0C,
        REG_TX_BAD    = 8'h10,
        REG_RX_FRAMES = 8'h14,
        REG_RX_BYTES  = 8'h18,
        REG_RX_BAD    = 8'h1C
    } reg_addr_e;

    // Response codes as on the AXI bus
    // Unmapped offsets answer SLVERR
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

endpackage : port_regs_pkg

// ==== source/cmac_pkg.sv ====
package cmac_pkg;

    // ======================================================================
    // Stream geometry
    // ======================================================================

    // Bytes per beat on both the transmit and the receive path
    // Top level default, passed down as a module parameter
    localparam int AXIS_DATA_BYTE_WID = 8;

    // ======================================================================
    // Stream sideband
    // ======================================================================

    // Single error flag
    // Only looked at on the last beat of a frame
    // Receive side means FCS error from the MAC
    // Transmit side means underrun or abort from the host
    typedef logic axis_tuser_t;

    // ======================================================================
    // Statistics
    // ======================================================================

    // Counter width
    localparam int STAT_CNT_WID = 32;

    // Frame, byte and error counters
    // Unsigned, free running, wraps at 2^32
    typedef logic [STAT_CNT_WID-1:0] stat_cnt_t;

endpackage : cmac_pkg
